/* hdl/spi_fmt_pkg.sv */
// Word width is fixed at 16 bits and size codes below 3 give 8-bit frames
`default_nettype none

package spi_fmt_pkg;

  localparam int DATA_W = 16;        // FIFO word width
  localparam int SIZE_W = 4;         // data_size field
  localparam int DIV_W = 23;         // Half-bit divider compare
  localparam int MIN_SIZE = 3;       // Smallest honored size code
  localparam int DEFAULT_SIZE = 7;   // Used below MIN_SIZE

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [SIZE_W-1:0] size_t; // Frame has size+1 bits
  typedef logic [DIV_W-1:0] div_t;   // Half bit is div+1 clocks

  // Size code actually used for a frame
  function automatic size_t eff_size(input size_t size);
    if (size < size_t'(MIN_SIZE))
      return size_t'(DEFAULT_SIZE);
    else
      return size;
  endfunction

endpackage

`default_nettype wire

/* hdl/spim_ctl_pkg.sv */
// Master only; STOP is one half bit, or three with nss_toggle
`default_nettype none

package spim_ctl_pkg;

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    START = 2'b01,
    DATA  = 2'b11,
    STOP  = 2'b10
  } frame_state_t;

  localparam int STOP_HALVES_TOGGLE = 3; // Half bits in STOP with nss_toggle
  localparam int STOP_CNT_W = 2;

  typedef logic [STOP_CNT_W-1:0] stop_cnt_t;
  typedef logic [spi_fmt_pkg::SIZE_W:0] bit_idx_t; // Half bits remaining

endpackage

`default_nettype wire

/* hdl/spim_tick_if.sv */
// Point to point from sequencer to shifter; strobes are valid for one clk only
`default_nettype none
`timescale 1ns/1ns

interface spim_tick_if;

  spim_ctl_pkg::frame_state_t state;   // Current frame phase
  logic                       tick;    // End of each half bit
  logic                       start_end;
  logic                       data_end; // Last DATA half bit ends
  spim_ctl_pkg::bit_idx_t     half_idx;
  spi_fmt_pkg::size_t         frame_size; // Latched at frame start

  modport seq (
    output state,
    output tick,
    output start_end,
    output data_end,
    output half_idx,
    output frame_size
  );

  modport shf (
    input state,
    input tick,
    input start_end,
    input data_end,
    input half_idx,
    input frame_size
  );

endinterface

`default_nettype wire

/* hdl/spim_sequencer.sv */
// Back-pressure only ends a burst at STOP and never stalls a frame in flight
`default_nettype none
`timescale 1ns/1ns

module spim_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_spim_en,
  input  logic                i_nss_toggle,
  input  logic                i_tx_en,
  input  logic                i_rx_en,
  input  logic                i_tx_empty,
  input  logic                i_rx_full,
  input  logic                i_intr_en,
  input  logic                i_stop_clr,
  input  spi_fmt_pkg::size_t  i_data_size,
  input  spi_fmt_pkg::div_t   i_clk_div,
  spim_tick_if.seq            o_tick,
  output logic                o_nss,
  output logic                o_stop_intr,
  output logic                o_busy
);

  spim_ctl_pkg::frame_state_t state_q;
  spim_ctl_pkg::frame_state_t state_d;
  spi_fmt_pkg::div_t          div_cnt_q;
  spim_ctl_pkg::bit_idx_t     half_idx_q;
  spim_ctl_pkg::stop_cnt_t    stop_cnt_q;
  spi_fmt_pkg::size_t         frame_size_q;
  logic                       tick;
  logic                       idle_start;
  logic                       start_end;
  logic                       data_end;
  logic                       stop_end;
  logic                       stop_cond;
  logic                       start_load;

  assign tick = (state_q != spim_ctl_pkg::IDLE) && (div_cnt_q == i_clk_div);

  // Word available on whichever sides are enabled
  assign idle_start = (state_q == spim_ctl_pkg::IDLE) && i_spim_en &&
                      ((i_tx_en && !i_rx_en && !i_tx_empty) ||
                       (!i_tx_en && i_rx_en && !i_rx_full) ||
                       (i_tx_en && i_rx_en && !i_tx_empty && !i_rx_full));

  assign start_end = (state_q == spim_ctl_pkg::START) && tick;
  assign data_end  = (state_q == spim_ctl_pkg::DATA) && tick && (half_idx_q == '0);
  assign stop_end  = (state_q == spim_ctl_pkg::STOP) && tick &&
                     (!i_nss_toggle ||
                      stop_cnt_q == spim_ctl_pkg::stop_cnt_t'(spim_ctl_pkg::STOP_HALVES_TOGGLE - 1));
  assign stop_cond = (i_tx_en && i_tx_empty) || (i_rx_en && i_rx_full);
  assign start_load = idle_start || (stop_end && !stop_cond);

  always_comb
  begin
    state_d = state_q;
    if (!i_spim_en)
      state_d = spim_ctl_pkg::IDLE;
    else
      case (state_q)
        spim_ctl_pkg::IDLE:  if (idle_start) state_d = spim_ctl_pkg::START;
        spim_ctl_pkg::START: if (start_end) state_d = spim_ctl_pkg::DATA;
        spim_ctl_pkg::DATA:  if (data_end) state_d = spim_ctl_pkg::STOP;
        spim_ctl_pkg::STOP:
          if (stop_end)
            state_d = stop_cond ? spim_ctl_pkg::IDLE : spim_ctl_pkg::START;
        default: state_d = spim_ctl_pkg::IDLE;
      endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= spim_ctl_pkg::IDLE;
    else
      state_q <= state_d;
  end

  // Half-bit divider restarts at each phase
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt_q <= '0;
    else if (state_q == spim_ctl_pkg::IDLE || tick)
      div_cnt_q <= '0;
    else
      div_cnt_q <= div_cnt_q + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      frame_size_q <= '0;
    else if (start_load)
      frame_size_q <= spi_fmt_pkg::eff_size(i_data_size);
  end

  // Counts 2*size+1 down to 0
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      half_idx_q <= '0;
    else if (start_end)
      half_idx_q <= {frame_size_q, 1'b1};
    else if (state_q != spim_ctl_pkg::DATA)
      half_idx_q <= '0;
    else if (tick && !data_end)
      half_idx_q <= half_idx_q - 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      stop_cnt_q <= '0;
    else if (state_q != spim_ctl_pkg::STOP || stop_end)
      stop_cnt_q <= '0;
    else if (tick)
      stop_cnt_q <= stop_cnt_q + 1'b1;
  end

  // With nss_toggle, chip select rises after the first STOP half bit
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      o_nss <= 1'b1;
    else if (!i_spim_en)
      o_nss <= 1'b1;
    else if (idle_start || (i_nss_toggle && stop_end && !stop_cond))
      o_nss <= 1'b0;
    else if (state_q == spim_ctl_pkg::IDLE ||
             (i_nss_toggle ? (state_q == spim_ctl_pkg::STOP && tick)
                           : (stop_end && stop_cond)))
      o_nss <= 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      o_stop_intr <= 1'b0;
    else if (i_stop_clr || !i_intr_en || !i_spim_en)
      o_stop_intr <= 1'b0;
    else if (stop_end && stop_cond)
      o_stop_intr <= 1'b1; // Sticky until cleared
  end

  assign o_busy = (state_q != spim_ctl_pkg::IDLE);

  assign o_tick.state      = state_q;
  assign o_tick.tick       = tick;
  assign o_tick.start_end  = start_end;
  assign o_tick.data_end   = data_end;
  assign o_tick.half_idx   = half_idx_q;
  assign o_tick.frame_size = frame_size_q;

endmodule

`default_nettype wire

/* hdl/spim_shifter.sv */
// MSB first; receive word reads zero above the frame length and is unset until a frame
`default_nettype none
`timescale 1ns/1ns

module spim_shifter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_spim_en,
  input  logic                i_cpol,
  input  logic                i_cpha,
  input  logic                i_tx_en,
  input  logic                i_rx_en,
  input  spi_fmt_pkg::word_t  i_tx_rd_data,
  input  logic                i_mi,
  spim_tick_if.shf            i_tick,
  output logic                o_mo,
  output logic                o_sck,
  output logic                o_tx_ren,
  output logic                o_rx_wen,
  output spi_fmt_pkg::word_t  o_rx_wr_data
);

  logic                              sck_q;
  logic                              mo_q;
  spi_fmt_pkg::word_t                rx_q;
  logic                              in_data;
  logic                              sample_edge;
  logic                              change_edge;
  logic [spi_fmt_pkg::SIZE_W-1:0]    bit_k;

  assign in_data = (i_tick.state == spim_ctl_pkg::DATA);
  assign bit_k   = i_tick.half_idx[spi_fmt_pkg::SIZE_W:1];

  // Sample edge is the one that takes sck to cpol^cpha^1
  assign sample_edge = in_data && i_tick.tick && (sck_q == (i_cpol ^ i_cpha));
  assign change_edge = in_data && i_tick.tick && !sample_edge && !i_tick.data_end;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sck_q <= 1'b0;
    else if (!i_spim_en)
      sck_q <= i_cpol;
    else if (!i_cpha)
    begin
      if (!in_data)
        sck_q <= i_cpol;
      else if (i_tick.tick)
        sck_q <= ~sck_q;
    end
    else
    begin
      if (i_tick.start_end)
        sck_q <= ~i_cpol; // Leading edge as START ends
      else if (!in_data || i_tick.data_end)
        sck_q <= i_cpol;
      else if (i_tick.tick)
        sck_q <= ~sck_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      mo_q <= 1'b0;
    else if (!i_spim_en || !i_tx_en)
      mo_q <= 1'b0;
    else if (i_tick.start_end)
      mo_q <= i_tx_rd_data[i_tick.frame_size]; // First bit is MSB
    else if (change_edge)
      mo_q <= i_tx_rd_data[bit_k - 1'b1];
  end

  always_ff @(posedge clk)
  begin
    if (i_tick.start_end)
      rx_q <= '0;
    else if (sample_edge && i_rx_en)
      rx_q[bit_k] <= i_mi;
  end

  assign o_sck        = sck_q;
  assign o_mo         = mo_q;
  assign o_rx_wr_data = rx_q;

  // rx_q already holds bit 0 in the last DATA cycle
  assign o_tx_ren = i_tick.data_end && i_tx_en;
  assign o_rx_wen = i_tick.data_end && i_rx_en;

endmodule

`default_nettype wire

/* hdl/spim_top.sv */
// SPI master only; FIFOs sit outside and must pop or push on the strobe cycle
`default_nettype none
`timescale 1ns/1ns

module spim_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_spim_en,
  input  logic                i_cpol,
  input  logic                i_cpha,
  input  logic                i_nss_toggle,
  input  spi_fmt_pkg::size_t  i_data_size,
  input  spi_fmt_pkg::div_t   i_clk_div,
  input  logic                i_tx_en,
  input  logic                i_rx_en,
  input  logic                i_tx_empty,
  input  logic                i_rx_full,
  input  spi_fmt_pkg::word_t  i_tx_rd_data,
  input  logic                i_intr_en,
  input  logic                i_stop_clr,
  input  logic                i_mi,
  output logic                o_mo,
  output logic                o_sck,
  output logic                o_nss,
  output logic                o_tx_ren,
  output logic                o_rx_wen,
  output spi_fmt_pkg::word_t  o_rx_wr_data,
  output logic                o_stop_intr,
  output logic                o_busy
);

  spim_tick_if u_tick ();

  // Timing and framing stage
  spim_sequencer u_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_spim_en    (i_spim_en),
    .i_nss_toggle (i_nss_toggle),
    .i_tx_en      (i_tx_en),
    .i_rx_en      (i_rx_en),
    .i_tx_empty   (i_tx_empty),
    .i_rx_full    (i_rx_full),
    .i_intr_en    (i_intr_en),
    .i_stop_clr   (i_stop_clr),
    .i_data_size  (i_data_size),
    .i_clk_div    (i_clk_div),
    .o_tick       (u_tick),
    .o_nss        (o_nss),
    .o_stop_intr  (o_stop_intr),
    .o_busy       (o_busy)
  );

  // Bit shifting stage
  spim_shifter u_shifter (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_spim_en    (i_spim_en),
    .i_cpol       (i_cpol),
    .i_cpha       (i_cpha),
    .i_tx_en      (i_tx_en),
    .i_rx_en      (i_rx_en),
    .i_tx_rd_data (i_tx_rd_data),
    .i_mi         (i_mi),
    .i_tick       (u_tick),
    .o_mo         (o_mo),
    .o_sck        (o_sck),
    .o_tx_ren     (o_tx_ren),
    .o_rx_wen     (o_rx_wen),
    .o_rx_wr_data (o_rx_wr_data)
  );

endmodule

`default_nettype wire

/* sim/spim_props.sv */
// Bound into spim_top; expects cpol to change only while the master is idle
`default_nettype none
`timescale 1ns/1ns

module spim_props (
  input logic clk,
  input logic rst_n,
  input logic i_cpol,
  input logic i_nss,
  input logic i_sck,
  input logic i_tx_ren,
  input logic i_rx_wen
);

  int fail_cnt = 0; // Failed assertion count

  assert property (@(posedge clk) disable iff (!rst_n) i_tx_ren |=> !i_tx_ren)
  else
  begin
    fail_cnt++;
    $error("tx read strobe wider than one cycle");
  end

  assert property (@(posedge clk) disable iff (!rst_n) i_rx_wen |=> !i_rx_wen)
  else
  begin
    fail_cnt++;
    $error("rx write strobe wider than one cycle");
  end

  // sck follows a new cpol one clock later
  assert property (@(posedge clk) disable iff (!rst_n)
                   i_nss && $stable(i_cpol) |-> i_sck == i_cpol)
  else
  begin
    fail_cnt++;
    $error("sck differs from cpol with chip select high");
  end

  assert property (@(posedge clk) disable iff (!rst_n) i_nss |-> !i_tx_ren && !i_rx_wen)
  else
  begin
    fail_cnt++;
    $error("FIFO strobe with chip select high");
  end

endmodule

bind spim_top spim_props u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .i_cpol   (i_cpol),
  .i_nss    (o_nss),
  .i_sck    (o_sck),
  .i_tx_ren (o_tx_ren),
  .i_rx_wen (o_rx_wen)
);

`default_nettype wire

/* sim/tb_clkgen.sv */
// 100 ns clock; rst_n is released 10 ns after the tenth rising edge
`default_nettype none
`timescale 1ns/1ns

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_NS = 50;
  localparam int RST_CYCLES = 10;

  initial
  begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #10 rst_n = 1'b1; // Off the clock edge like other inputs
  end

endmodule

`default_nettype wire

/* sim/tb_spim.sv */
// o_mo loops back to i_mi; the transmit FIFO is a queue and config changes only when idle
`default_nettype none
`timescale 1ns/1ns

module tb_spim;

  typedef struct packed {
    logic               cpol;
    logic               cpha;
    logic               toggle;
    logic               intr_en;
    spi_fmt_pkg::size_t size;
    spi_fmt_pkg::div_t  div;
    logic [2:0]         words;
  } burst_t;

  logic                clk;
  logic                rst_n;
  logic                i_spim_en;
  logic                i_cpol;
  logic                i_cpha;
  logic                i_nss_toggle;
  spi_fmt_pkg::size_t  i_data_size;
  spi_fmt_pkg::div_t   i_clk_div;
  logic                i_tx_en;
  logic                i_rx_en;
  logic                i_tx_empty;
  logic                i_rx_full;
  spi_fmt_pkg::word_t  i_tx_rd_data;
  logic                i_intr_en;
  logic                i_stop_clr;
  logic                i_mi;
  logic                o_mo;
  logic                o_sck;
  logic                o_nss;
  logic                o_tx_ren;
  logic                o_rx_wen;
  spi_fmt_pkg::word_t  o_rx_wr_data;
  logic                o_stop_intr;
  logic                o_busy;

  spi_fmt_pkg::word_t  tx_q[$];
  burst_t              bursts[$];
  spi_fmt_pkg::size_t  cur_size;
  string               test_name;
  integer              seed;
  int                  err_cnt;
  int                  cycles;
  int                  cycle_limit;
  int                  rx_count;
  int                  sck_edges;
  int                  nss_rises;
  logic                count_pending;
  logic                prev_sck;
  logic                prev_nss;

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  spim_top i_spim_top (.*);

  assign i_mi = o_mo; // Loopback

  function automatic int frame_bits(input spi_fmt_pkg::size_t size);
    if (size < 3)
      return 8;
    return int'(size) + 1;
  endfunction

  // Expected receive word for a looped-back transmit word
  function automatic spi_fmt_pkg::word_t ref_rx_word(input spi_fmt_pkg::word_t tx,
                                                     input spi_fmt_pkg::size_t size);
    logic [31:0] mask;
    mask = (32'h1 << frame_bits(size)) - 1;
    return tx & mask[spi_fmt_pkg::DATA_W-1:0];
  endfunction

  // START, DATA and the long STOP, plus slack
  function automatic int frame_bound(input spi_fmt_pkg::size_t size,
                                     input spi_fmt_pkg::div_t div);
    return (int'(div) + 1) * (4 + 2 * frame_bits(size)) + 4;
  endfunction

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input spi_fmt_pkg::word_t exp,
                            input spi_fmt_pkg::word_t act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
      report_failure($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic next_drive_slot();
    @(posedge clk);
    #10;
  endtask

  task automatic wait_busy(input logic level);
    do
      @(negedge clk);
    while (o_busy !== level);
  endtask

  task automatic clear_stop_intr();
    next_drive_slot();
    i_stop_clr = 1'b1;
    next_drive_slot();
    i_stop_clr = 1'b0;
    @(negedge clk);
    check_bit({test_name, " stop_intr cleared"}, 1'b0, o_stop_intr);
  endtask

  task automatic run_burst(input burst_t b, input int idx);
    int n;
    next_drive_slot();
    i_cpol       = b.cpol;
    i_cpha       = b.cpha;
    i_nss_toggle = b.toggle;
    i_intr_en    = b.intr_en;
    i_data_size  = b.size;
    i_clk_div    = b.div;
    i_tx_en      = 1'b1;
    i_rx_en      = 1'b1;
    cur_size     = b.size;
    test_name    = $sformatf("burst%0d", idx);
    rx_count     = 0;
    nss_rises    = 0;
    sck_edges    = 0;
    @(posedge clk);
    for (n = 0; n < int'(b.words); n++)
      tx_q.push_back(spi_fmt_pkg::word_t'($random(seed)));
    wait_busy(1'b1);
    wait_busy(1'b0);
    check_count({test_name, " words"}, int'(b.words), rx_count);
    check_count({test_name, " queue left"}, 0, tx_q.size());
    // Every STOP raises chip select with toggle, the last one included
    check_count({test_name, " nss rises"}, b.toggle ? int'(b.words) : 0, nss_rises);
    check_bit({test_name, " stop_intr"}, b.intr_en, o_stop_intr);
    clear_stop_intr();
  endtask

  task automatic run_rx_only();
    int base;
    next_drive_slot();
    i_cpol       = 1'b1;
    i_cpha       = 1'b0;
    i_nss_toggle = 1'b0;
    i_intr_en    = 1'b1;
    i_data_size  = 4'd5;
    i_clk_div    = 1;
    i_tx_en      = 1'b0;
    i_rx_en      = 1'b1;
    i_rx_full    = 1'b0;
    cur_size     = 4'd5;
    test_name    = "rx_only";
    rx_count     = 0;
    sck_edges    = 0;
    wait_busy(1'b1);
    while (rx_count < 3)
      @(negedge clk);
    // Skip STOP and START so that full rises inside DATA
    repeat (2 * (int'(i_clk_div) + 1) + 2) @(posedge clk);
    #10;
    i_rx_full = 1'b1;
    base = rx_count;
    wait_busy(1'b0);
    check_count({test_name, " words after full"}, 1, rx_count - base);
    check_bit({test_name, " stop_intr"}, 1'b1, o_stop_intr);
    next_drive_slot();
    i_rx_en   = 1'b0;
    i_rx_full = 1'b0;
    clear_stop_intr();
  endtask

  // Transmit FIFO outputs follow the queue
  always
  begin
    @(posedge clk);
    #10;
    i_tx_empty   = (tx_q.size() == 0);
    i_tx_rd_data = (tx_q.size() == 0) ? '0 : tx_q[0];
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit)
      report_failure($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
  end

  always @(negedge clk)
  begin : monitor
    spi_fmt_pkg::word_t popped;
    popped = '0;
    if (rst_n)
    begin
      if (i_spim_top.u_props.fail_cnt != 0)
        report_failure("a bound assertion on the DUT failed");
      if (!o_nss && o_sck !== prev_sck)
        sck_edges++;
      if (count_pending)
      begin
        check_count({test_name, " sck edges"}, 2 * frame_bits(cur_size), sck_edges);
        sck_edges = 0;
        count_pending = 1'b0;
      end
      if (!i_tx_en)
      begin
        check_bit({test_name, " tx_ren"}, 1'b0, o_tx_ren);
        if (!o_nss)
          check_bit({test_name, " mo"}, 1'b0, o_mo);
      end
      if (o_tx_ren)
      begin
        if (tx_q.size() == 0)
          report_failure("transmit FIFO read while it was empty");
        else
          popped = tx_q.pop_front();
      end
      if (o_rx_wen)
      begin
        check_word({test_name, " rx word"}, ref_rx_word(popped, cur_size), o_rx_wr_data);
        rx_count++;
      end
      if (o_tx_ren || o_rx_wen)
        count_pending = 1'b1; // Last sck edge shows one cycle later
      if (!prev_nss && o_nss && o_busy)
        nss_rises++;
    end
    prev_sck = o_sck;
    prev_nss = o_nss;
  end

  initial
  begin : stimulus
    burst_t b;
    int     t;
    int     limit;
    seed         = 32'h48e7755d;
    i_spim_en    = 1'b0;
    i_cpol       = 1'b0;
    i_cpha       = 1'b0;
    i_nss_toggle = 1'b0;
    i_data_size  = '0;
    i_clk_div    = '0;
    i_tx_en      = 1'b0;
    i_rx_en      = 1'b0;
    i_tx_empty   = 1'b1;
    i_rx_full    = 1'b0;
    i_tx_rd_data = '0;
    i_intr_en    = 1'b0;
    i_stop_clr   = 1'b0;
    test_name    = "reset";
    limit        = 140;
    for (t = 0; t < 8; t++)
    begin
      b.cpol    = t[1];
      b.cpha    = t[0];
      b.toggle  = t[2];
      b.intr_en = (t % 3 != 2);
      case (t)
        1: b.size = 4'd1;
        2: b.size = 4'd0;
        6: b.size = 4'd2;
        default: b.size = spi_fmt_pkg::size_t'(3 + $unsigned($random(seed)) % 13);
      endcase
      b.div   = spi_fmt_pkg::div_t'($unsigned($random(seed)) % 3);
      b.words = 3'(2 + $unsigned($random(seed)) % 3);
      bursts.push_back(b);
      limit += int'(b.words) * frame_bound(b.size, b.div) + 10;
    end
    limit += 6 * frame_bound(4'd5, 1) + 10;
    cycle_limit = limit;

    repeat (3) @(negedge clk);
    check_bit("reset nss", 1'b1, o_nss);
    check_bit("reset sck", 1'b0, o_sck);
    check_bit("reset tx_ren", 1'b0, o_tx_ren);
    check_bit("reset rx_wen", 1'b0, o_rx_wen);
    check_bit("reset stop_intr", 1'b0, o_stop_intr);
    wait (rst_n);
    next_drive_slot();
    i_spim_en = 1'b1;
    @(negedge clk);
    check_bit("idle nss", 1'b1, o_nss);
    check_bit("idle busy", 1'b0, o_busy);

    for (t = 0; t < bursts.size(); t++)
      run_burst(bursts[t], t);
    run_rx_only();

    next_drive_slot();
    if (err_cnt == 0 && i_spim_top.u_props.fail_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hdl/spi_fmt_pkg.sv
hdl/spim_ctl_pkg.sv
hdl/spim_tick_if.sv
hdl/spim_sequencer.sv
hdl/spim_shifter.sv
hdl/spim_top.sv
sim/spim_props.sv
sim/tb_clkgen.sv
sim/tb_spim.sv

/* Bender.yml */
package:
  name: spim

sources:
  - hdl/spi_fmt_pkg.sv
  - hdl/spim_ctl_pkg.sv
  - hdl/spim_tick_if.sv
  - hdl/spim_sequencer.sv
  - hdl/spim_shifter.sv
  - hdl/spim_top.sv
  - target: simulation
    files:
      - sim/spim_props.sv
      - sim/tb_clkgen.sv
      - sim/tb_spim.sv
